/* list.f */
+incdir+.
psum_pkg.sv
glb_bank.sv
glb_read_arbiter.sv
psum_fifo.sv
psum_fifo_ctrl.sv
psum_accumulator.sv
psum_prefetch_top.sv
tb_psum_prefetch.sv

/* Bender.yml */
package:
  name: psum_prefetch

sources:
  - include_dirs:
      - .
    files:
      - psum_pkg.sv
      - glb_bank.sv
      - glb_read_arbiter.sv
      - psum_fifo.sv
      - psum_fifo_ctrl.sv
      - psum_accumulator.sv
      - psum_prefetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_psum_prefetch.sv

/* tb_psum_prefetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module tb_psum_prefetch
    import psum_pkg::*;
();

    localparam int LANES           = `PSUM_LANES;
    localparam int GLB_DEPTH       = `PSUM_GLB_DEPTH;
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_ROWS        = 6;
    localparam int WAIT_LIMIT      = 300;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 400 + GLB_DEPTH + 16;

    localparam logic [LANES-1:0] ALL_IDLE = '1;

    logic                     clk;
    logic                     rst_n;
    psum_task_t [LANES-1:0]   task_in;
    logic [LANES-1:0][31:0]   base_addr;
    logic                     glb_wr_en;
    logic [31:0]              glb_wr_addr;
    psum_word_t               glb_wr_data;
    lane_result_t [LANES-1:0] result;
    logic [LANES-1:0]         idle;

    psum_word_t glb_copy [GLB_DEPTH];
    int         pop_count [LANES];
    int         error_count;
    int         check_count;
    int         failed_tests;

    // Stimulus table where mask bit l selects lane l
    logic [LANES-1:0] row_mask [NUM_ROWS] = '{4'b0001, 4'b0010, 4'b1111,
                                              4'b1111, 4'b0101, 4'b1010};
    logic [4:0] row_pop [NUM_ROWS][LANES] = '{'{5'd3, 5'd0, 5'd0, 5'd0},
                                              '{5'd0, 5'd20, 5'd0, 5'd0},
                                              '{5'd5, 5'd7, 5'd9, 5'd4},
                                              '{5'd6, 5'd3, 5'd11, 5'd2},
                                              '{5'd4, 5'd0, 5'd8, 5'd0},
                                              '{5'd0, 5'd17, 5'd0, 5'd13}};
    logic  row_reset [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    string row_name [NUM_ROWS]  = '{"single_lane_refill", "long_task_refills",
                                    "all_lanes_compete", "continue_no_reset",
                                    "restart_with_reset", "continue_after_restart"};

    psum_prefetch_top i_psum_prefetch_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .task_i        (task_in),
        .base_addr_i   (base_addr),
        .glb_wr_en_i   (glb_wr_en),
        .glb_wr_addr_i (glb_wr_addr),
        .glb_wr_data_i (glb_wr_data),
        .result_o      (result),
        .idle_o        (idle)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic logic [LANES-1:0] valid_bits();
        logic [LANES-1:0] v;
        for (int l = 0; l < LANES; l++) begin
            v[l] = result[l].valid;
        end
        return v;
    endfunction

    // Popped stream of a lane is the GLB run starting at its base
    function automatic psum_word_t expected_sum(input int lane, input int start, input int n);
        psum_word_t sum;
        sum = '0;
        for (int k = 0; k < n; k++) begin
            sum += glb_copy[(base_addr[lane] + start + k) % GLB_DEPTH];
        end
        return sum;
    endfunction

    task automatic load_glb();
        for (int a = 0; a < GLB_DEPTH; a++) begin
            @(negedge clk);
            glb_wr_en   = 1'b1;
            glb_wr_addr = a;
            glb_wr_data = glb_copy[a];
            compare_value("result_valid", valid_bits(), '0);
        end
        @(negedge clk);
        glb_wr_en = 1'b0;
    endtask

    task automatic run_row(input int r);
        logic [LANES-1:0] seen;
        int               errors_before;
        int               cycles;
        errors_before = error_count;
        seen          = '0;
        cycles        = 0;
        if (row_reset[r]) begin
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                if (row_mask[r][l]) begin
                    task_in[l].fifo_reset = 1'b1;
                    pop_count[l]          = 0;
                end
            end
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                task_in[l].fifo_reset = 1'b0;
            end
        end
        @(negedge clk);
        for (int l = 0; l < LANES; l++) begin
            if (row_mask[r][l]) begin
                task_in[l].need_pop = 1'b1;
                task_in[l].pop_num  = row_pop[r][l];
            end
        end
        @(negedge clk);
        for (int l = 0; l < LANES; l++) begin
            task_in[l].need_pop = 1'b0;
        end
        // Collect one result pulse from every started lane
        while (seen != row_mask[r] && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            for (int l = 0; l < LANES; l++) begin
                if (result[l].valid) begin
                    if (!row_mask[r][l] || seen[l]) begin
                        error_count++;
                        $display("Unexpected result pulse on lane %0d", l);
                    end else begin
                        seen[l] = 1'b1;
                        compare_value($sformatf("result_o[%0d].sum", l), result[l].sum,
                                      expected_sum(l, pop_count[l], row_pop[r][l]));
                        pop_count[l] += row_pop[r][l];
                    end
                end
            end
        end
        for (int l = 0; l < LANES; l++) begin
            if (row_mask[r][l] && !seen[l]) begin
                error_count++;
                $display("Lane %0d gave no result pulse within %0d cycles", l, WAIT_LIMIT);
            end
        end
        compare_value("idle_o", idle, ALL_IDLE);
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("Test %0d %s: %s", r + 1, row_name[r],
                 (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        rst_n        = 1'b0;
        task_in      = '0;
        glb_wr_en    = 1'b0;
        glb_wr_addr  = '0;
        glb_wr_data  = '0;
        error_count  = 0;
        check_count  = 0;
        failed_tests = 0;
        for (int l = 0; l < LANES; l++) begin
            base_addr[l] = 32'(l * 64);
            pop_count[l] = 0;
        end
        void'($urandom(32'hdba4));
        for (int a = 0; a < GLB_DEPTH; a++) begin
            glb_copy[a] = $urandom;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("idle_o", idle, ALL_IDLE);
        // Valid must stay low through the GLB load as well
        load_glb();
        $display("Test 0 reset_state: %s", (error_count == 0) ? "ok" : "FAILED");
        if (error_count != 0) begin
            failed_tests++;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 NUM_ROWS + 1, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* psum_prefetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module psum_prefetch_top
    import psum_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  psum_task_t [`PSUM_LANES-1:0]   task_i,
    input  logic [`PSUM_LANES-1:0][31:0]   base_addr_i,
    input  logic                           glb_wr_en_i,
    input  logic [31:0]                    glb_wr_addr_i,
    input  psum_word_t                     glb_wr_data_i,
    output lane_result_t [`PSUM_LANES-1:0] result_o,
    output logic [`PSUM_LANES-1:0]         idle_o
);

    localparam int LANES = `PSUM_LANES;

    glb_req_t [LANES-1:0]   glb_req;
    logic [LANES-1:0]       permit;
    logic [LANES-1:0]       push;
    logic [LANES-1:0]       pop;
    logic [LANES-1:0]       fifo_full;
    logic [LANES-1:0]       fifo_empty;
    psum_word_t [LANES-1:0] head;
    logic [31:0]            glb_rd_addr;
    psum_word_t             glb_rd_data;

    glb_bank i_glb_bank (
        .clk       (clk),
        .wr_en_i   (glb_wr_en_i),
        .wr_addr_i (glb_wr_addr_i),
        .wr_data_i (glb_wr_data_i),
        .rd_addr_i (glb_rd_addr),
        .rd_data_o (glb_rd_data)
    );

    glb_read_arbiter i_glb_read_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (glb_req),
        .permit_o  (permit),
        .rd_addr_o (glb_rd_addr)
    );

    // One controller and FIFO per lane with the GLB word broadcast to all
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        psum_fifo_ctrl i_psum_fifo_ctrl (
            .clk          (clk),
            .rst_n        (rst_n),
            .task_i       (task_i[g]),
            .base_addr_i  (base_addr_i[g]),
            .permit_i     (permit[g]),
            .fifo_full_i  (fifo_full[g]),
            .fifo_empty_i (fifo_empty[g]),
            .glb_req_o    (glb_req[g]),
            .push_o       (push[g]),
            .pop_o        (pop[g]),
            .idle_o       (idle_o[g])
        );

        psum_fifo i_psum_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .clear_i     (task_i[g].fifo_reset),
            .push_i      (push[g]),
            .push_data_i (glb_rd_data),
            .pop_i       (pop[g]),
            .head_o      (head[g]),
            .full_o      (fifo_full[g]),
            .empty_o     (fifo_empty[g])
        );
    end

    psum_accumulator i_psum_accumulator (
        .clk      (clk),
        .rst_n    (rst_n),
        .pop_i    (pop),
        .head_i   (head),
        .idle_i   (idle_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

/* psum_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module psum_accumulator
    import psum_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`PSUM_LANES-1:0]         pop_i,
    input  psum_word_t [`PSUM_LANES-1:0]   head_i,
    input  logic [`PSUM_LANES-1:0]         idle_i,
    output lane_result_t [`PSUM_LANES-1:0] result_o
);

    localparam int LANES = `PSUM_LANES;

    psum_word_t [LANES-1:0] acc_q;
    psum_word_t [LANES-1:0] res_sum_q;
    logic [LANES-1:0]       idle_q;
    logic [LANES-1:0]       valid_q;
    logic [LANES-1:0]       done;

    // Task finished when idle goes high
    assign done = idle_i & ~idle_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= '0;
            idle_q  <= '1;
            valid_q <= '0;
        end else begin
            idle_q  <= idle_i;
            valid_q <= done;
            for (int l = 0; l < LANES; l++) begin
                if (done[l]) begin
                    acc_q[l] <= '0;
                end else if (pop_i[l]) begin
                    acc_q[l] <= acc_q[l] + head_i[l];
                end
            end
        end
    end

    // Snapshot of the finished sum
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (done[l]) begin
                res_sum_q[l] <= acc_q[l];
            end
        end
    end

    for (genvar g = 0; g < LANES; g++) begin : g_result
        assign result_o[g].valid = valid_q[g];
        assign result_o[g].sum   = res_sum_q[g];
    end

endmodule

`default_nettype wire

/* psum_fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module psum_fifo_ctrl
    import psum_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  psum_task_t  task_i,
    input  logic [31:0] base_addr_i,
    input  logic        permit_i,
    input  logic        fifo_full_i,
    input  logic        fifo_empty_i,
    output glb_req_t    glb_req_o,
    output logic        push_o,
    output logic        pop_o,
    output logic        idle_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_POP,
        ST_REFILL
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic [4:0]  pop_num_q;
    logic [4:0]  pop_cnt_q;
    logic [31:0] rd_ptr_q;
    logic        last_pop;

    assign pop_o    = (state_q == ST_POP) && !fifo_empty_i;
    assign last_pop = pop_o && (pop_cnt_q == pop_num_q - 5'd1);

    // Fetch from the GLB only while refilling and there is room
    assign glb_req_o.req  = (state_q == ST_REFILL) && !fifo_full_i;
    assign glb_req_o.addr = base_addr_i + rd_ptr_q;
    assign push_o         = glb_req_o.req && permit_i;

    assign idle_o = (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (task_i.need_pop) begin
                    state_d = ST_POP;
                end
            end
            ST_POP: begin
                // Task ends on exactly the pop_num-th pop
                if (last_pop) begin
                    state_d = ST_IDLE;
                end else if (fifo_empty_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (fifo_full_i) begin
                    state_d = ST_POP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            pop_num_q <= '0;
            pop_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                pop_num_q <= task_i.pop_num;
                pop_cnt_q <= '0;
            end else if (pop_o) begin
                pop_cnt_q <= pop_cnt_q + 5'd1;
            end
        end
    end

    // GLB read pointer as an offset from the lane base
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
        end else if (task_i.fifo_reset) begin
            rd_ptr_q <= '0;
        end else if (push_o) begin
            rd_ptr_q <= rd_ptr_q + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* psum_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module psum_fifo
    import psum_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear_i,
    input  logic       push_i,
    input  psum_word_t push_data_i,
    input  logic       pop_i,
    output psum_word_t head_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int DEPTH = `PSUM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    psum_word_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Show-ahead head keeps the oldest word on the output
    assign head_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* glb_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module glb_read_arbiter
    import psum_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  glb_req_t [`PSUM_LANES-1:0] req_i,
    output logic [`PSUM_LANES-1:0]   permit_o,
    output logic [31:0]              rd_addr_o
);

    localparam int LANES = `PSUM_LANES;
    localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] grant_idx;
    logic             found;

    // First requester at or after the pointer wins
    always_comb begin
        int unsigned cand;
        permit_o  = '0;
        rd_addr_o = '0;
        grant_idx = ptr_q;
        found     = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            cand = (ptr_q + i) % LANES;
            if (!found && req_i[cand].req) begin
                found           = 1'b1;
                grant_idx       = cand[IDX_W-1:0];
                permit_o[cand]  = 1'b1;
                rd_addr_o       = req_i[cand].addr;
            end
        end
    end

    // Move past the granted lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (found) begin
            if (grant_idx == IDX_W'(LANES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* glb_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psum_settings.svh"

module glb_bank
    import psum_pkg::*;
(
    input  logic        clk,
    input  logic        wr_en_i,
    input  logic [31:0] wr_addr_i,
    input  psum_word_t  wr_data_i,
    input  logic [31:0] rd_addr_i,
    output psum_word_t  rd_data_o
);

    localparam int DEPTH  = `PSUM_GLB_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    psum_word_t mem [DEPTH];

    // Loaded by the host before any task runs
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    // Same-cycle read straight into the lane FIFOs
    assign rd_data_o = mem[rd_addr_i[ADDR_W-1:0]];

endmodule

`default_nettype wire

/* psum_pkg.sv */
`default_nettype none

`include "psum_settings.svh"

package psum_pkg;

    typedef logic [`PSUM_DATA_W-1:0] psum_word_t;

    // Task strobes from the layer controller to one lane
    typedef struct packed {
        logic       need_pop;
        logic [4:0] pop_num;
        logic       fifo_reset;
    } psum_task_t;

    // Read request from one lane towards the GLB arbiter
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } glb_req_t;

    // Completion report of one lane
    typedef struct packed {
        logic       valid;
        psum_word_t sum;
    } lane_result_t;

endpackage

`default_nettype wire

/* psum_settings.svh */
`ifndef PSUM_SETTINGS_SVH
`define PSUM_SETTINGS_SVH

// Number of partial-sum lanes
`define PSUM_LANES 4

// Words held by each lane FIFO
`define PSUM_FIFO_DEPTH 8

// Words in the global buffer
`define PSUM_GLB_DEPTH 256

// Width of one data word
`define PSUM_DATA_W 32

`endif
